// File: rtl/flags_rename_pkg.sv
package flags_rename_pkg;

  // ------------------------------------------------------------
  // widths and counts
  // ------------------------------------------------------------
  localparam int tag_w     = 9;   // physical register tag
  localparam int funit_w   = 10;
  localparam int slots     = 3;   // instructions per rename bundle
  localparam int ret_ports = 3;
  localparam int threads   = 2;
  localparam int sel_w     = 4;

  typedef logic [tag_w-1:0]   tag_t;
  typedef logic [funit_w-1:0] funit_t;
  typedef logic [sel_w-1:0]   sel_t;

  // ------------------------------------------------------------
  // read select codes
  // ------------------------------------------------------------
  // codes 0..slots-1 forward from that earlier slot of the bundle
  localparam sel_t sel_table = 4'he; // entry as it stands
  localparam sel_t sel_arch  = 4'hd; // entry with retired forced

  localparam funit_t funit_reset = 10'h009;

  // one flags mapping, also the result of any flags read
  typedef struct packed
  {
    tag_t   tag;
    funit_t funit;
    logic   retired;
  } flags_map_t;

endpackage

// File: rtl/flags_write_if.sv
`timescale 1ns/1ps

interface flags_write_if import flags_rename_pkg::*; ();

  tag_t   [slots-1:0] new_tag;
  funit_t [slots-1:0] new_funit;
  logic   [slots-1:0] wen;
  logic               wr_thread; // latched bundle thread

  modport src
  (
    output new_tag,
    output new_funit,
    output wen,
    output wr_thread
  );

  // table update side
  modport state
  (
    input new_tag,
    input new_funit,
    input wen,
    input wr_thread
  );

  // in-bundle forwarding only needs the payload
  modport fwd
  (
    input new_tag,
    input new_funit
  );

endinterface

// File: rtl/flags_bundle_latch.sv
`timescale 1ns/1ps

module flags_bundle_latch import flags_rename_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  logic               read_en,
  input  sel_t [slots-1:0]   rd_sel,
  input  logic               thread,
  output sel_t [slots-1:0]   sel_q,
  output logic               thread_q
);

  sel_t [slots-1:0] sel_r;
  logic             thread_r;

  // ------------------------------------------------------------
  // read stage registers
  // ------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      sel_r    <= '0;
      thread_r <= 1'b0;
    end
    else if (read_en) // low read_en holds the bundle
    begin
      sel_r    <= rd_sel;
      thread_r <= thread;
    end
  end

  assign sel_q    = sel_r;
  assign thread_q = thread_r; // also the write thread

endmodule

// File: rtl/flags_map_state.sv
`timescale 1ns/1ps

module flags_map_state import flags_rename_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  flags_write_if.state           wr,
  input  tag_t [ret_ports-1:0]   ret_tag,
  input  logic [ret_ports-1:0]   ret_wen,
  input  logic                   retire_all,
  input  logic                   ret_thread,
  input  logic                   rd_thread,
  output flags_map_t             rd_entry
);

  flags_map_t map_q [threads];
  flags_map_t new_entry;
  logic       any_wen;
  logic       ret_hit;

  // ------------------------------------------------------------
  // rename write, youngest enabled slot wins
  // ------------------------------------------------------------
  always_comb
  begin
    new_entry = '0; // retired stays clear
    any_wen   = 1'b0;
    for (int s = 0; s < slots; s++)
    begin
      if (wr.wen[s])
      begin
        new_entry.tag   = wr.new_tag[s];
        new_entry.funit = wr.new_funit[s];
        any_wen         = 1'b1;
      end
    end
  end

  // retire ports against the stored tag of ret_thread
  always_comb
  begin
    ret_hit = 1'b0;
    for (int p = 0; p < ret_ports; p++)
    begin
      if (ret_wen[p] && ret_tag[p] == map_q[ret_thread].tag)
        ret_hit = 1'b1;
    end
  end

  // ------------------------------------------------------------
  // per-thread entries
  // ------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    for (int t = 0; t < threads; t++)
    begin
      if (rst)
      begin
        map_q[t].tag     <= '0;
        map_q[t].funit   <= funit_reset;
        map_q[t].retired <= 1'b1;
      end
      else if (any_wen && int'(wr.wr_thread) == t)
      begin
        map_q[t] <= new_entry; // rename beats retire
      end
      else if (int'(ret_thread) == t && (ret_hit || retire_all))
      begin
        map_q[t].retired <= 1'b1;
      end
    end
  end

  assign rd_entry = map_q[rd_thread];

endmodule

// File: rtl/flags_read_select.sv
`timescale 1ns/1ps

module flags_read_select import flags_rename_pkg::*;
(
  input  sel_t       [slots-1:0] sel,
  input  flags_map_t             table_entry,
  flags_write_if.fwd             fw,
  output flags_map_t [slots-1:0] result
);

  flags_map_t [slots-1:0] res;

  // ------------------------------------------------------------
  // per-slot source choice
  // ------------------------------------------------------------
  always_comb
  begin
    for (int s = 0; s < slots; s++)
    begin
      res[s] = '0; // unknown codes read as zero
      if (sel[s] == sel_table)
      begin
        res[s] = table_entry;
      end
      else if (sel[s] == sel_arch)
      begin
        res[s]         = table_entry;
        res[s].retired = 1'b1;
      end
      else
      begin
        // only slots older than this one can forward
        for (int j = 0; j < s; j++)
        begin
          if (sel[s] == sel_t'(j))
          begin
            res[s].tag     = fw.new_tag[j];
            res[s].funit   = fw.new_funit[j];
            res[s].retired = 1'b0; // producer still in flight
          end
        end
      end
    end
  end

  assign result = res;

endmodule

// File: rtl/flags_rename_top.sv
`timescale 1ns/1ps

module flags_rename_top import flags_rename_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  logic   read_en,
  input  logic   thread,
  input  sel_t   rd_sel0,
  input  sel_t   rd_sel1,
  input  sel_t   rd_sel2,
  input  tag_t   new_tag0,
  input  tag_t   new_tag1,
  input  tag_t   new_tag2,
  input  funit_t new_funit0,
  input  funit_t new_funit1,
  input  funit_t new_funit2,
  input  logic   new_wen0,
  input  logic   new_wen1,
  input  logic   new_wen2,
  input  tag_t   ret_tag0,
  input  tag_t   ret_tag1,
  input  tag_t   ret_tag2,
  input  logic   ret_wen0,
  input  logic   ret_wen1,
  input  logic   ret_wen2,
  input  logic   retire_all,
  input  logic   ret_thread,
  output tag_t   res_tag0,
  output tag_t   res_tag1,
  output tag_t   res_tag2,
  output funit_t res_funit0,
  output funit_t res_funit1,
  output funit_t res_funit2,
  output logic   res_retired0,
  output logic   res_retired1,
  output logic   res_retired2
);

  sel_t       [slots-1:0] sel_q;
  logic                   thread_q;
  flags_map_t             rd_entry;
  flags_map_t [slots-1:0] result;

  flags_write_if wr ();

  // ------------------------------------------------------------
  // bundle write side
  // ------------------------------------------------------------
  assign wr.new_tag   = {new_tag2, new_tag1, new_tag0};
  assign wr.new_funit = {new_funit2, new_funit1, new_funit0};
  assign wr.wen       = {new_wen2, new_wen1, new_wen0};
  assign wr.wr_thread = thread_q;

  flags_bundle_latch u_latch
  (
    .clk      (clk),
    .rst      (rst),
    .read_en  (read_en),
    .rd_sel   ({rd_sel2, rd_sel1, rd_sel0}),
    .thread   (thread),
    .sel_q    (sel_q),
    .thread_q (thread_q)
  );

  flags_map_state u_state
  (
    .clk        (clk),
    .rst        (rst),
    .wr         (wr),
    .ret_tag    ({ret_tag2, ret_tag1, ret_tag0}),
    .ret_wen    ({ret_wen2, ret_wen1, ret_wen0}),
    .retire_all (retire_all),
    .ret_thread (ret_thread),
    .rd_thread  (thread_q),
    .rd_entry   (rd_entry)
  );

  flags_read_select u_select
  (
    .sel         (sel_q),
    .table_entry (rd_entry),
    .fw          (wr),
    .result      (result)
  );

  assign res_tag0     = result[0].tag;
  assign res_tag1     = result[1].tag;
  assign res_tag2     = result[2].tag;
  assign res_funit0   = result[0].funit;
  assign res_funit1   = result[1].funit;
  assign res_funit2   = result[2].funit;
  assign res_retired0 = result[0].retired;
  assign res_retired1 = result[1].retired;
  assign res_retired2 = result[2].retired;

endmodule

// File: tb/flags_rename_model.svh
`ifndef FLAGS_RENAME_MODEL_SVH
`define FLAGS_RENAME_MODEL_SVH

// reference copy of the table and of the latched read stage
flags_map_t       m_entry [threads];
sel_t [slots-1:0] m_sel;
logic             m_thread;

function automatic void model_reset();
  for (int t = 0; t < threads; t++)
    m_entry[t] = '{tag: '0, funit: funit_reset, retired: 1'b1};
  m_sel    = '0;
  m_thread = 1'b0;
endfunction

// one clock edge, the arguments are the inputs of the cycle it ends
function automatic void model_clock(input logic rd_en, input logic thr,
                                    input sel_t [slots-1:0] sel, input tag_t [slots-1:0] tag,
                                    input funit_t [slots-1:0] fu, input logic [slots-1:0] wen,
                                    input tag_t [ret_ports-1:0] rtag,
                                    input logic [ret_ports-1:0] rwen,
                                    input logic rall, input logic rthr);
  int   young;
  logic hit;
  young = -1;
  hit   = rall;
  for (int s = 0; s < slots; s++)
    if (wen[s])
      young = s;
  for (int p = 0; p < ret_ports; p++)
    if (rwen[p] && rtag[p] == m_entry[rthr].tag)
      hit = 1'b1;
  if (young >= 0)
    m_entry[m_thread] = '{tag: tag[young], funit: fu[young], retired: 1'b0};
  if (hit && !(young >= 0 && m_thread == rthr)) // rename on that thread wins
    m_entry[rthr].retired = 1'b1;
  if (rd_en)
  begin
    m_sel    = sel;
    m_thread = thr;
  end
endfunction

// what one slot reads in the cycle after its select was latched
function automatic flags_map_t expect_read(input sel_t sel, input int slot,
                                           input tag_t [slots-1:0] tag,
                                           input funit_t [slots-1:0] fu);
  flags_map_t e;
  int         src;
  e   = '0;
  src = int'(sel);
  if (sel == sel_table)
    e = m_entry[m_thread];
  else if (sel == sel_arch)
    e = '{tag: m_entry[m_thread].tag, funit: m_entry[m_thread].funit, retired: 1'b1};
  else if (src < slot)
    e = '{tag: tag[src], funit: fu[src], retired: 1'b0};
  return e;
endfunction

`endif

// File: tb/flags_rename_tb.sv
`timescale 1ns/1ps

module flags_rename_tb import flags_rename_pkg::*;
();

  localparam int unsigned seed         = 32'hc0eb_9362;
  localparam int          reset_cycles = 5;
  localparam int          rand_bundles = 300;

  logic                   clk;
  logic                   rst;
  logic                   read_en;
  logic                   thread;
  logic                   retire_all;
  logic                   ret_thread;
  sel_t   [slots-1:0]     rd_sel;
  tag_t   [slots-1:0]     new_tag;
  funit_t [slots-1:0]     new_funit;
  logic   [slots-1:0]     new_wen;
  tag_t   [ret_ports-1:0] ret_tag;
  logic   [ret_ports-1:0] ret_wen;
  tag_t                   res_tag0, res_tag1, res_tag2;
  funit_t                 res_funit0, res_funit1, res_funit2;
  logic                   res_retired0, res_retired1, res_retired2;

  // values for the coming edge
  logic                   nx_rst;
  logic                   nx_read_en;
  logic                   nx_thread;
  logic                   nx_retire_all;
  logic                   nx_ret_thread;
  sel_t   [slots-1:0]     nx_sel;
  tag_t   [slots-1:0]     nx_tag;
  funit_t [slots-1:0]     nx_funit;
  logic   [slots-1:0]     nx_wen;
  tag_t   [ret_ports-1:0] nx_ret_tag;
  logic   [ret_ports-1:0] nx_ret_wen;

  flags_map_t [slots-1:0] got;
  flags_map_t [slots-1:0] exp_res = '0;
  int                     errors  = 0;
  int                     bundles = 0;

  `include "flags_rename_model.svh"

  flags_rename_top u_flags_rename_top
  (
    .*,
    .rd_sel0    (rd_sel[0]),    .rd_sel1    (rd_sel[1]),    .rd_sel2    (rd_sel[2]),
    .new_tag0   (new_tag[0]),   .new_tag1   (new_tag[1]),   .new_tag2   (new_tag[2]),
    .new_funit0 (new_funit[0]), .new_funit1 (new_funit[1]), .new_funit2 (new_funit[2]),
    .new_wen0   (new_wen[0]),   .new_wen1   (new_wen[1]),   .new_wen2   (new_wen[2]),
    .ret_tag0   (ret_tag[0]),   .ret_tag1   (ret_tag[1]),   .ret_tag2   (ret_tag[2]),
    .ret_wen0   (ret_wen[0]),   .ret_wen1   (ret_wen[1]),   .ret_wen2   (ret_wen[2])
  );

  assign got = {res_tag2, res_funit2, res_retired2,
                res_tag1, res_funit1, res_retired1,
                res_tag0, res_funit0, res_retired0};

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ------------------------------------------------------------
  // checking mid-cycle while everything is stable
  // ------------------------------------------------------------
  a_result : assert property (@(negedge clk) disable iff (rst) got === exp_res)
    else report_mismatch();

  task automatic report_mismatch();
    errors++;
    for (int s = 0; s < slots; s++)
      if (got[s] !== exp_res[s])
        $display("Error %0t: slot %0d read tag %h funit %h retired %b, expected %h %h %b",
                 $time, s, got[s].tag, got[s].funit, got[s].retired,
                 exp_res[s].tag, exp_res[s].funit, exp_res[s].retired);
  endtask

  // ------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------
  task automatic cycle();
    flags_map_t [slots-1:0] nx_exp;
    @(posedge clk);
    if (rst)
      model_reset();
    else
      model_clock(read_en, thread, rd_sel, new_tag, new_funit, new_wen, ret_tag, ret_wen,
                  retire_all, ret_thread);
    for (int s = 0; s < slots; s++)
      nx_exp[s] = expect_read(m_sel[s], s, nx_tag, nx_funit);
    rst        <= nx_rst;
    read_en    <= nx_read_en;
    thread     <= nx_thread;
    rd_sel     <= nx_sel;
    new_tag    <= nx_tag;
    new_funit  <= nx_funit;
    new_wen    <= nx_wen;
    ret_tag    <= nx_ret_tag;
    ret_wen    <= nx_ret_wen;
    retire_all <= nx_retire_all;
    ret_thread <= nx_ret_thread;
    exp_res    <= nx_exp;
    if (nx_read_en)
      bundles++;
    nx_read_en    = 1'b0; // strobes last one cycle
    nx_wen        = '0;
    nx_ret_wen    = '0;
    nx_retire_all = 1'b0;
  endtask

  task automatic read_bundle(input logic thr, input sel_t s0, input sel_t s1, input sel_t s2);
    nx_read_en = 1'b1;
    nx_thread  = thr;
    nx_sel     = {s2, s1, s0};
    cycle();
  endtask

  task automatic set_write(input int s, input tag_t tag, input funit_t fu);
    nx_wen[s]   = 1'b1;
    nx_tag[s]   = tag;
    nx_funit[s] = fu;
  endtask

  task automatic set_retire(input int p, input tag_t tag, input logic thr);
    nx_ret_wen[p] = 1'b1;
    nx_ret_tag[p] = tag;
    nx_ret_thread = thr;
  endtask

  function automatic sel_t random_sel();
    case ($urandom_range(0, 5))
      0: return sel_table;
      1: return sel_arch;
      5: return sel_t'($urandom()); // mostly unused codes
      default: return sel_t'($urandom_range(0, slots - 1));
    endcase
  endfunction

  task automatic random_bundle();
    nx_read_en    = ($urandom_range(0, 4) != 0);
    nx_thread     = 1'($urandom_range(0, 1));
    nx_ret_thread = 1'($urandom_range(0, 1));
    nx_retire_all = ($urandom_range(0, 15) == 0);
    for (int s = 0; s < slots; s++)
    begin
      nx_sel[s]   = random_sel();
      nx_tag[s]   = tag_t'($urandom());
      nx_funit[s] = funit_t'($urandom());
      nx_wen[s]   = ($urandom_range(0, 2) == 0);
    end
    for (int p = 0; p < ret_ports; p++)
    begin
      nx_ret_wen[p] = ($urandom_range(0, 3) == 0);
      nx_ret_tag[p] = $urandom_range(0, 1) ? m_entry[nx_ret_thread].tag : tag_t'($urandom());
    end
    cycle();
  endtask

  initial
  begin
    void'($urandom(seed));
    rst = 1'b1;
    {read_en, thread, retire_all, ret_thread, rd_sel, new_tag, new_funit, new_wen,
     ret_tag, ret_wen} = '0;
    {nx_read_en, nx_thread, nx_retire_all, nx_ret_thread, nx_sel, nx_tag, nx_funit, nx_wen,
     nx_ret_tag, nx_ret_wen} = '0;
    nx_rst = 1'b1;
    repeat (reset_cycles - 1) cycle();
    nx_rst = 1'b0;
    cycle();

    read_bundle(1'b0, sel_table, sel_arch, sel_table); // reset values
    read_bundle(1'b1, sel_table, sel_arch, 4'h7);
    read_bundle(1'b0, sel_table, sel_table, sel_table);
    set_write(0, 9'h011, 10'h101); // youngest slot 2 wins
    set_write(2, 9'h033, 10'h303);
    set_write(1, 9'h022, 10'h202);
    read_bundle(1'b1, sel_table, sel_table, sel_table);
    read_bundle(1'b0, sel_table, sel_arch, sel_table);
    // in-bundle forwarding next to old table reads
    read_bundle(1'b1, sel_arch, 4'h0, 4'h1);
    set_write(0, 9'h044, 10'h144);
    set_write(1, 9'h055, 10'h155);
    read_bundle(1'b1, sel_table, 4'h0, 4'h2);
    set_write(2, 9'h066, 10'h166);
    read_bundle(1'b1, 4'h0, sel_table, 4'h9);
    set_retire(0, 9'h1ff, 1'b0); // no match
    cycle();
    set_retire(1, 9'h033, 1'b0);
    read_bundle(1'b0, sel_table, sel_arch, sel_table);
    set_write(2, 9'h088, 10'h188); // thread 0 live again before retire_all
    read_bundle(1'b1, sel_table, sel_table, sel_table);
    set_write(0, 9'h077, 10'h177); // rename beats a same-cycle retire
    set_retire(2, 9'h066, 1'b1);
    read_bundle(1'b1, sel_table, sel_table, sel_table);
    nx_retire_all = 1'b1;
    nx_ret_thread = 1'b1;
    read_bundle(1'b0, sel_table, sel_table, sel_table);
    read_bundle(1'b1, sel_table, sel_arch, sel_table);
    // stall with changed selects while the table still moves
    read_bundle(1'b0, sel_table, sel_arch, 4'h1);
    nx_thread = 1'b1;
    nx_sel    = {sel_arch, sel_t'(0), sel_table};
    set_write(1, 9'h0aa, 10'h2aa);
    repeat (3) cycle();

    for (int i = 0; i < rand_bundles; i++)
      random_bundle();
    repeat (2) cycle();

    $display("bundles %0d, errors %0d", bundles, errors);
    if (errors == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// File: flags_rename.f
+incdir+tb
rtl/flags_rename_pkg.sv
rtl/flags_write_if.sv
rtl/flags_bundle_latch.sv
rtl/flags_map_state.sv
rtl/flags_read_select.sv
rtl/flags_rename_top.sv
tb/flags_rename_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/1ps
TOP       = flags_rename_tb
FILELIST  = flags_rename.f
OBJDIR    = obj_dir
PASS_MSG  = Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@out=$$(./$(OBJDIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
